// ==== list.f ====
+incdir+dv
source/bridge_bus_pkg.sv
source/bridge_map_pkg.sv
source/reg_access_if.sv
source/bridge_cmd_decoder.sv
source/bridge_config_reg.sv
source/bridge_scratchpad.sv
source/bridge_rsp_collector.sv
source/bridge_top.sv
dv/bridge_tb.sv

// ==== dv/bridge_model.svh ====
`ifndef BRIDGE_MODEL_SVH
`define BRIDGE_MODEL_SVH

// Expected response of one command.
typedef struct packed
{
  bridge_opcode_e           op;
  bridge_status_e           status;
  logic [data_width_lp-1:0] data;
  logic                     known;
} rsp_exp_t;

// Registers come out of reset as zero, as do the two-state model values.
bit   [data_width_lp-1:0] model_cfg    [num_cfg_regs_lp];
logic [data_width_lp-1:0] model_sp     [scratchpad_els_lp];
bit                       model_sp_set [scratchpad_els_lp];

// Register index 0 to 3 in map order, 4 for a scratchpad word, -1 when unmapped.
function automatic int model_target(input logic [addr_width_lp-1:0] addr);
  if (addr[15:8] == scratchpad_base_lp[15:8] && addr[1:0] == 2'b00)
    return 4;
  case (addr)
    cfg_dram_offset_addr_lp: return 0;
    cfg_dram_pod_addr_lp:    return 1;
    cfg_my_cord_addr_lp:     return 2;
    cfg_host_cord_addr_lp:   return 3;
    default:                 return -1;
  endcase
endfunction

// Applies a write and predicts the response.
// Data of a never written scratchpad word is marked unknown.
function automatic rsp_exp_t model_access(input bridge_opcode_e           op,
                                          input logic [addr_width_lp-1:0] addr,
                                          input logic [data_width_lp-1:0] wdata);
  rsp_exp_t                            exp;
  int                                  tgt;
  logic [scratchpad_addr_width_lp-1:0] word;
  tgt        = model_target(addr);
  word       = addr[7:2];
  exp.op     = op;
  exp.status = (tgt < 0) ? e_status_error : e_status_okay;
  exp.data   = '0;
  exp.known  = 1'b1;
  if (tgt >= 0 && op == e_op_write)
  begin
    if (tgt == 4)
    begin
      model_sp[word]     = wdata;
      model_sp_set[word] = 1'b1;
    end
    else
      model_cfg[tgt] = wdata;
  end
  else if (tgt == 4)
  begin
    exp.data  = model_sp[word];
    exp.known = model_sp_set[word];
  end
  else if (tgt >= 0)
    exp.data = model_cfg[tgt];
  return exp;
endfunction

`endif

// ==== dv/bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_tb
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
();

  localparam int num_cmds_lp       = 400;
  localparam int max_stall_lp      = 7;
  localparam int timeout_cycles_lp = num_cmds_lp * 4 * (max_stall_lp + 1) + 100;

  logic                         clk_i;
  logic                         reset_i;
  logic                         cmd_v_i;
  bridge_opcode_e               cmd_opcode_i;
  logic [addr_width_lp-1:0]     cmd_addr_i;
  logic [data_width_lp-1:0]     cmd_data_i;
  logic                         cmd_ready_o;
  logic                         rsp_v_o;
  bridge_status_e               rsp_status_o;
  bridge_opcode_e               rsp_opcode_o;
  logic [data_width_lp-1:0]     rsp_data_o;
  logic                         rsp_ready_i;
  logic [data_width_lp-1:0]     dram_offset_o;
  logic [pod_cord_width_lp-1:0] dram_pod_o;
  logic [cord_width_lp-1:0]     my_cord_o;
  logic [cord_width_lp-1:0]     host_cord_o;

  `include "bridge_model.svh"

  integer   seed = 44955;
  integer   ready_seed;
  int       stall_count = 0;
  int       rsp_count = 0;
  logic     outstanding;
  logic     held_v;
  rsp_exp_t held;
  rsp_exp_t exp_q [$];

  bridge_top i_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
      fail_run($sformatf("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual));
  endtask

  // Top-level outputs are the low bits of the four registers.
  task automatic check_outputs(input string name);
    check_value({name, " dram_offset_o"}, model_cfg[0], dram_offset_o);
    check_value({name, " dram_pod_o"}, model_cfg[1][pod_cord_width_lp-1:0], dram_pod_o);
    check_value({name, " my_cord_o"}, model_cfg[2][cord_width_lp-1:0], my_cord_o);
    check_value({name, " host_cord_o"}, model_cfg[3][cord_width_lp-1:0], host_cord_o);
  endtask

  task automatic take_response();
    rsp_exp_t exp;
    if (exp_q.size() == 0)
      fail_run("A response arrived while no command was outstanding.");
    else
    begin
      exp = exp_q.pop_front();
      check_value("response rsp_opcode_o", exp.op, rsp_opcode_o);
      check_value("response rsp_status_o", exp.status, rsp_status_o);
      if (exp.known)
        check_value("response rsp_data_o", exp.data, rsp_data_o);
      check_outputs("response");
      outstanding = 1'b0;
      rsp_count++;
    end
  endtask

  // Back-pressure and response checks share one clocked process.
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rsp_ready_i <= 1'b0;
      outstanding = 1'b0;
      held_v      = 1'b0;
    end
    else
    begin
      if (held_v)
      begin
        check_value("stall rsp_v_o", 1'b1, rsp_v_o);
        check_value("stall rsp_opcode_o", held.op, rsp_opcode_o);
        check_value("stall rsp_status_o", held.status, rsp_status_o);
        check_value("stall rsp_data_o", held.data, rsp_data_o);
      end
      if (outstanding)
        check_value("busy cmd_ready_o", 1'b0, cmd_ready_o);
      if (rsp_v_o && rsp_ready_i)
        take_response();
      else if (cmd_v_i && cmd_ready_o)
        outstanding = 1'b1;
      held_v = rsp_v_o && !rsp_ready_i;
      held   = {rsp_opcode_o, rsp_status_o, rsp_data_o, 1'b1};
      if (stall_count < max_stall_lp && ($random(ready_seed) & 1))
      begin
        rsp_ready_i <= 1'b0;
        stall_count++;
      end
      else
      begin
        rsp_ready_i <= 1'b1;
        stall_count = 0;
      end
    end
  end

  initial
  begin
    repeat (timeout_cycles_lp) @(posedge clk_i);
    fail_run($sformatf("Timeout with %0d of %0d responses received.", rsp_count, num_cmds_lp));
  end

  initial
  begin : stimulus
    bridge_opcode_e           op;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
    reset_i      = 1'b1;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = e_op_read;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    rsp_ready_i  = 1'b0;
    ready_seed   = $random(seed);
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("reset cmd_ready_o", 1'b1, cmd_ready_o);
    check_value("reset rsp_v_o", 1'b0, rsp_v_o);
    check_outputs("reset");
    for (int n = 0; n < num_cmds_lp; n++)
    begin
      op   = ($random(seed) & 1) ? e_op_write : e_op_read;
      data = $random(seed);
      case ($random(seed) & 7)
        0, 1:    addr = cfg_addrs_lp[$random(seed) & 3];
        2, 3, 4: addr = scratchpad_base_lp + 16'(($random(seed) & 63) << 2);
        // Odd addresses match neither a register nor a scratchpad word.
        5, 6:    addr = 16'($random(seed)) | 16'h0001;
        default: addr = 16'($random(seed)) | 16'h2000;
      endcase
      exp_q.push_back(model_access(op, addr, data));
      cmd_v_i      <= 1'b1;
      cmd_opcode_i <= op;
      cmd_addr_i   <= addr;
      cmd_data_i   <= data;
      do
        @(posedge clk_i);
      while (!cmd_ready_o);
      cmd_v_i <= 1'b0;
      do
        @(posedge clk_i);
      while (!(rsp_v_o && rsp_ready_i));
      // The model moves on only after the monitor has checked this response.
      repeat (1 + ($random(seed) & 3)) @(posedge clk_i);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_top
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic                         cmd_v_i,
  input  bridge_opcode_e               cmd_opcode_i,
  input  logic [addr_width_lp-1:0]     cmd_addr_i,
  input  logic [data_width_lp-1:0]     cmd_data_i,
  output logic                         cmd_ready_o,

  output logic                         rsp_v_o,
  output bridge_status_e               rsp_status_o,
  output bridge_opcode_e               rsp_opcode_o,
  output logic [data_width_lp-1:0]     rsp_data_o,
  input  logic                         rsp_ready_i,

  output logic [data_width_lp-1:0]     dram_offset_o,
  output logic [pod_cord_width_lp-1:0] dram_pod_o,
  output logic [cord_width_lp-1:0]     my_cord_o,
  output logic [cord_width_lp-1:0]     host_cord_o
);

  reg_access_if acc ();

  logic rsp_done;

  bridge_cmd_decoder i_decoder
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_opcode_i (cmd_opcode_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .rsp_done_i   (rsp_done),
    .acc          (acc)
  );

  for (genvar i = 0; i < num_cfg_regs_lp; i++)
  begin : g_cfg
    bridge_config_reg #(.idx_p(i)) i_cfg_reg
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .slot    (acc)
    );
  end

  bridge_scratchpad i_scratchpad
  (
    .clk_i (clk_i),
    .mem   (acc)
  );

  bridge_rsp_collector i_collector
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .acc          (acc),
    .rsp_v_o      (rsp_v_o),
    .rsp_status_o (rsp_status_o),
    .rsp_opcode_o (rsp_opcode_o),
    .rsp_data_o   (rsp_data_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_done_o   (rsp_done)
  );

  // Register outputs carry only the low bits that the fabric uses.
  assign dram_offset_o = acc.cfg_rdata[cfg_dram_offset_idx_lp];
  assign dram_pod_o    = acc.cfg_rdata[cfg_dram_pod_idx_lp][pod_cord_width_lp-1:0];
  assign my_cord_o     = acc.cfg_rdata[cfg_my_cord_idx_lp][cord_width_lp-1:0];
  assign host_cord_o   = acc.cfg_rdata[cfg_host_cord_idx_lp][cord_width_lp-1:0];

endmodule

`default_nettype wire

// ==== source/bridge_rsp_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_rsp_collector
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  reg_access_if.collector          acc,

  output logic                     rsp_v_o,
  output bridge_status_e           rsp_status_o,
  output bridge_opcode_e           rsp_opcode_o,
  output logic [data_width_lp-1:0] rsp_data_o,
  input  logic                     rsp_ready_i,

  output logic                     rsp_done_o
);

  logic           rsp_v_r;
  bridge_status_e status_r;
  bridge_opcode_e opcode_r;
  bridge_target_e target_r;

  logic                     hit;
  logic [data_width_lp-1:0] rdata_sel;

  // Any strobe in the access cycle means the address was mapped.
  assign hit = (|acc.cfg_w_v) | (|acc.cfg_r_v) | acc.sp_v;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_r <= 1'b0;
    else if (acc.access_v)
      rsp_v_r <= 1'b1;
    else if (rsp_done_o)
      rsp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (acc.access_v)
    begin
      status_r <= hit ? e_status_okay : e_status_error;
      opcode_r <= acc.opcode;
      target_r <= acc.target;
    end
  end

  // Sources cannot change while the response waits, so a live select is stable.
  always_comb
  begin
    rdata_sel = '0;
    for (int i = 0; i < num_cfg_regs_lp; i++)
      if (target_r == bridge_target_e'(i))
        rdata_sel = acc.cfg_rdata[i];
    if (target_r == e_tgt_scratchpad)
      rdata_sel = acc.sp_rdata;
  end

  assign rsp_v_o      = rsp_v_r;
  assign rsp_status_o = status_r;
  assign rsp_opcode_o = opcode_r;
  assign rsp_data_o   = (opcode_r == e_op_read && status_r == e_status_okay) ? rdata_sel : '0;
  assign rsp_done_o   = rsp_v_r & rsp_ready_i;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (rsp_v_o && !rsp_ready_i) |=> (rsp_v_o && $stable(rsp_status_o)
                                   && $stable(rsp_opcode_o) && $stable(rsp_data_o)));

  // The decoder must not start an access while a response is still pending.
  a_no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    acc.access_v |-> !rsp_v_r);

endmodule

`default_nettype wire

// ==== source/bridge_scratchpad.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_scratchpad
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
(
  input logic          clk_i,

  reg_access_if.memory mem
);

  logic [data_width_lp-1:0] ram_r [scratchpad_els_lp];
  logic [data_width_lp-1:0] rdata_r;

  always_ff @(posedge clk_i)
  begin
    if (mem.sp_v && mem.sp_w)
      ram_r[mem.word_addr] <= mem.wdata;
  end

  // Read data holds until the next read, so it stays valid while the response waits.
  always_ff @(posedge clk_i)
  begin
    if (mem.sp_v && !mem.sp_w)
      rdata_r <= ram_r[mem.word_addr];
  end

  assign mem.sp_rdata = rdata_r;

endmodule

`default_nettype wire

// ==== source/bridge_config_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_config_reg
  import bridge_bus_pkg::*;
#(
  parameter int idx_p = 0
)
(
  input logic            clk_i,
  input logic            reset_i,

  reg_access_if.cfg_slot slot
);

  logic [data_width_lp-1:0] value_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      value_r <= '0;
    else if (slot.cfg_w_v[idx_p])
      value_r <= slot.wdata;
  end

  // Always visible, both for read-back and for the top-level outputs.
  assign slot.cfg_rdata[idx_p] = value_r;

endmodule

`default_nettype wire

// ==== source/bridge_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_cmd_decoder
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     cmd_v_i,
  input  bridge_opcode_e           cmd_opcode_i,
  input  logic [addr_width_lp-1:0] cmd_addr_i,
  input  logic [data_width_lp-1:0] cmd_data_i,
  output logic                     cmd_ready_o,

  input  logic                     rsp_done_i,

  reg_access_if.decoder            acc
);

  typedef enum logic [1:0]
  {
    e_idle,
    e_access,
    e_wait_rsp
  } state_e;

  state_e state_r, state_n;

  bridge_opcode_e           opcode_r;
  logic [addr_width_lp-1:0] addr_r;
  logic [data_width_lp-1:0] data_r;

  logic                       cmd_accept;
  logic [num_cfg_regs_lp-1:0] cfg_hit;
  logic                       sp_hit;
  logic                       is_write;

  assign cmd_ready_o = (state_r == e_idle);
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle:     if (cmd_accept) state_n = e_access;
      e_access:   state_n = e_wait_rsp;
      e_wait_rsp: if (rsp_done_i) state_n = e_idle;
      default:    state_n = e_idle;
    endcase
  end

  // The command stays latched until the next accept.
  always_ff @(posedge clk_i)
  begin
    if (cmd_accept)
    begin
      opcode_r <= cmd_opcode_i;
      addr_r   <= cmd_addr_i;
      data_r   <= cmd_data_i;
    end
  end

  // Exact match on register bases, aligned words inside the scratchpad window.
  always_comb
  begin
    for (int i = 0; i < num_cfg_regs_lp; i++)
      cfg_hit[i] = (addr_r == cfg_addrs_lp[i]);
    sp_hit = (addr_r[addr_width_lp-1:scratchpad_window_lsb_lp]
              == scratchpad_base_lp[addr_width_lp-1:scratchpad_window_lsb_lp])
             && (addr_r[byte_offset_width_lp-1:0] == '0);
    acc.target = e_tgt_none;
    if (sp_hit)
      acc.target = e_tgt_scratchpad;
    for (int i = 0; i < num_cfg_regs_lp; i++)
      if (cfg_hit[i])
        acc.target = bridge_target_e'(i);
  end

  assign is_write = (opcode_r == e_op_write);

  assign acc.access_v  = (state_r == e_access);
  assign acc.opcode    = opcode_r;
  assign acc.cfg_w_v   = (acc.access_v && is_write) ? cfg_hit : '0;
  assign acc.cfg_r_v   = (acc.access_v && !is_write) ? cfg_hit : '0;
  assign acc.sp_v      = acc.access_v & sp_hit;
  assign acc.sp_w      = is_write;
  assign acc.word_addr = addr_r[scratchpad_window_lsb_lp-1:byte_offset_width_lp];
  assign acc.wdata     = data_r;

  a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({acc.cfg_w_v, acc.cfg_r_v, acc.sp_v}));

  // Only the response of the command in flight may release the FSM back to idle.
  a_done_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_done_i |-> (state_r == e_wait_rsp));

endmodule

`default_nettype wire

// ==== source/reg_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if
  import bridge_bus_pkg::*;
  import bridge_map_pkg::*;
();

  // High for the single access cycle of every command, mapped or not.
  logic                       access_v;
  bridge_opcode_e             opcode;
  logic [num_cfg_regs_lp-1:0] cfg_w_v;
  logic [num_cfg_regs_lp-1:0] cfg_r_v;
  logic                       sp_v;
  logic                       sp_w;

  logic [scratchpad_addr_width_lp-1:0] word_addr;
  logic [data_width_lp-1:0]            wdata;
  bridge_target_e                      target;

  logic [data_width_lp-1:0] cfg_rdata [num_cfg_regs_lp];
  logic [data_width_lp-1:0] sp_rdata;

  modport decoder
  (
    output access_v, opcode, cfg_w_v, cfg_r_v, sp_v, sp_w, word_addr, wdata, target
  );

  modport cfg_slot
  (
    input  cfg_w_v, wdata,
    output cfg_rdata
  );

  modport memory
  (
    input  sp_v, sp_w, word_addr, wdata,
    output sp_rdata
  );

  modport collector
  (
    input access_v, opcode, target, cfg_w_v, cfg_r_v, sp_v, cfg_rdata, sp_rdata
  );

endinterface

`default_nettype wire

// ==== source/bridge_map_pkg.sv ====
`default_nettype none

// Device address map and the targets behind it.
package bridge_map_pkg;

  localparam int num_cfg_regs_lp = 4;

  localparam logic [bridge_bus_pkg::addr_width_lp-1:0] cfg_dram_offset_addr_lp = 16'h0000;
  localparam logic [bridge_bus_pkg::addr_width_lp-1:0] cfg_dram_pod_addr_lp    = 16'h0008;
  localparam logic [bridge_bus_pkg::addr_width_lp-1:0] cfg_my_cord_addr_lp     = 16'h0010;
  localparam logic [bridge_bus_pkg::addr_width_lp-1:0] cfg_host_cord_addr_lp   = 16'h0018;

  // Slot order of the register array, index 0 on the right.
  localparam logic [num_cfg_regs_lp-1:0][bridge_bus_pkg::addr_width_lp-1:0] cfg_addrs_lp =
    {cfg_host_cord_addr_lp, cfg_my_cord_addr_lp, cfg_dram_pod_addr_lp, cfg_dram_offset_addr_lp};

  localparam int cfg_dram_offset_idx_lp = 0;
  localparam int cfg_dram_pod_idx_lp    = 1;
  localparam int cfg_my_cord_idx_lp     = 2;
  localparam int cfg_host_cord_idx_lp   = 3;

  localparam logic [bridge_bus_pkg::addr_width_lp-1:0] scratchpad_base_lp = 16'h1000;
  localparam int scratchpad_els_lp        = 64;
  localparam int scratchpad_addr_width_lp = 6;

  // Lowest address bit that is fixed inside the scratchpad window.
  localparam int scratchpad_window_lsb_lp =
    scratchpad_addr_width_lp + bridge_bus_pkg::byte_offset_width_lp;

  localparam int pod_cord_width_lp = 8;
  localparam int cord_width_lp     = 14;

  typedef enum logic [2:0]
  {
    e_tgt_config0, e_tgt_config1, e_tgt_config2, e_tgt_config3, e_tgt_scratchpad, e_tgt_none
  } bridge_target_e;

endpackage

`default_nettype wire

// ==== source/bridge_bus_pkg.sv ====
`default_nettype none

// Host command bus: word size, address size and the channel field encodings.
package bridge_bus_pkg;

  localparam int data_width_lp = 32;
  localparam int addr_width_lp = 16;

  // Bytes per word, expressed as address bits below the word index.
  localparam int byte_offset_width_lp = 2;

  typedef enum logic [0:0]
  {
    e_op_read  = 1'b0,
    e_op_write = 1'b1
  } bridge_opcode_e;

  typedef enum logic [0:0]
  {
    e_status_okay  = 1'b0,
    e_status_error = 1'b1
  } bridge_status_e;

endpackage

`default_nettype wire
